// File: verilog/video_gen_params.svh
`ifndef VIDEO_GEN_PARAMS_SVH
`define VIDEO_GEN_PARAMS_SVH

// horizontal geometry, offscreen columns come first in each line
`define H_TOTAL         40              // clocks per line
`define H_OFFSCREEN     8               // blank columns before the visible area
`define H_VISIBLE       32              // H_TOTAL - H_OFFSCREEN
`define H_SYNC_START    2               // hsync asserted from this column
`define H_SYNC_END      5               // hsync released at this column

// vertical geometry, visible lines come first in each frame
`define V_TOTAL         12              // lines per frame
`define V_VISIBLE       8               // visible lines
`define V_SYNC_START    9               // vsync asserted from this line
`define V_SYNC_END      10              // vsync released at this line

`define MEM_LEAD        4               // fetch starts this many clocks before first pixel

// video register numbers
`define XR_VID_CTRL     0
`define XR_VID_LEFT     4
`define XR_VID_RIGHT    5
`define XR_SCANLINE     8
`define XR_VID_HSIZE    10
`define XR_VID_VSIZE    11

// playfield register numbers
`define XR_PA_GFX_CTRL  16
`define XR_PA_DISP_ADDR 18
`define XR_PA_LINE_LEN  19

`define BORDER_RESET    8'h08           // dark grey so a live display is visible
`define VSYNC_INTR      3               // end of visible area interrupt bit

`endif

// File: verilog/video_gen_pkg.sv
`default_nettype none

// vector types shared by the video generator and its testbench
package video_gen_pkg;

// register and memory data
typedef logic [15:0]    word_t;         // register or vram word
typedef logic [15:0]    addr_t;         // vram word address

// pixel data
typedef logic [7:0]     color_t;        // palette index

// raster counters
typedef logic [5:0]     hres_t;         // column count
typedef logic [3:0]     vres_t;         // line count

// register bus and interrupts
typedef logic [5:0]     reg_num_t;      // config register number
typedef logic [3:0]     intr_t;         // interrupt vector

endpackage

`default_nettype wire

// File: verilog/video_timing.sv
`default_nettype none
`timescale 1ns/1ns

`include "video_gen_params.svh"

module video_timing (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    output      video_gen_pkg::hres_t   h_count_o,          // current column
    output      video_gen_pkg::vres_t   v_count_o,          // current line
    output      logic                   h_visible_o,
    output      logic                   v_visible_o,
    output      logic                   end_of_line_o,      // last column of every line
    output      logic                   end_of_visible_o,   // last column of last visible line
    output      logic                   hsync_o,
    output      logic                   vsync_o,
    output      logic                   dv_de_o
);

localparam video_gen_pkg::hres_t H_LAST       = video_gen_pkg::hres_t'(`H_TOTAL - 1);
localparam video_gen_pkg::hres_t H_VIS_START  = video_gen_pkg::hres_t'(`H_OFFSCREEN);
localparam video_gen_pkg::hres_t H_SYNC_BEGIN = video_gen_pkg::hres_t'(`H_SYNC_START);
localparam video_gen_pkg::hres_t H_SYNC_STOP  = video_gen_pkg::hres_t'(`H_SYNC_END);
localparam video_gen_pkg::vres_t V_LAST       = video_gen_pkg::vres_t'(`V_TOTAL - 1);
localparam video_gen_pkg::vres_t V_VIS_END    = video_gen_pkg::vres_t'(`V_VISIBLE);
localparam video_gen_pkg::vres_t V_VIS_LAST   = video_gen_pkg::vres_t'(`V_VISIBLE - 1);
localparam video_gen_pkg::vres_t V_SYNC_BEGIN = video_gen_pkg::vres_t'(`V_SYNC_START);
localparam video_gen_pkg::vres_t V_SYNC_STOP  = video_gen_pkg::vres_t'(`V_SYNC_END);

logic h_vis;                                                // column is in the visible area
logic v_vis;                                                // line is in the visible area

// event strobes follow the counters directly
assign end_of_line_o    = (h_count_o == H_LAST);
assign end_of_visible_o = end_of_line_o && (v_count_o == V_VIS_LAST);

assign h_vis = (h_count_o >= H_VIS_START);
assign v_vis = (v_count_o < V_VIS_END);

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count_o   <= '0;
        v_count_o   <= '0;
        h_visible_o <= 1'b0;
        v_visible_o <= 1'b0;
        hsync_o     <= 1'b0;
        vsync_o     <= 1'b0;
        dv_de_o     <= 1'b0;
    end else begin
        if (end_of_line_o) begin
            h_count_o <= '0;
            if (v_count_o == V_LAST) begin
                v_count_o <= '0;                            // frame wrap
            end else begin
                v_count_o <= v_count_o + video_gen_pkg::vres_t'(1);
            end
        end else begin
            h_count_o <= h_count_o + video_gen_pkg::hres_t'(1);
        end

        // levels lag the counters by one clock
        h_visible_o <= h_vis;
        v_visible_o <= v_vis;
        hsync_o     <= (h_count_o >= H_SYNC_BEGIN) && (h_count_o < H_SYNC_STOP);
        vsync_o     <= (v_count_o >= V_SYNC_BEGIN) && (v_count_o < V_SYNC_STOP);
        dv_de_o     <= h_vis && v_vis;
    end
end

endmodule

`default_nettype wire

// File: verilog/video_regs.sv
`default_nettype none
`timescale 1ns/1ns

`include "video_gen_params.svh"

module video_regs (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_en_i,    // write strobe
    input  wire video_gen_pkg::reg_num_t    reg_num_i,      // register for write and read
    input  wire video_gen_pkg::word_t       reg_data_i,     // write data
    input  wire video_gen_pkg::vres_t       v_count_i,      // current line for SCANLINE
    input  wire logic                       end_of_visible_i,
    output      video_gen_pkg::word_t       reg_data_o,     // read data, one clock after reg_num_i
    output      video_gen_pkg::intr_t       intr_signal_o,  // one clock interrupt pulses
    output      video_gen_pkg::color_t      border_color_o,
    output      video_gen_pkg::color_t      colorbase_o,
    output      logic                       blank_o,
    output      video_gen_pkg::hres_t       vid_left_o,
    output      video_gen_pkg::hres_t       vid_right_o,
    output      video_gen_pkg::word_t       disp_addr_o,
    output      video_gen_pkg::word_t       line_len_o
);

video_gen_pkg::word_t rd_data;                              // read-back word before the register

// register writes and interrupt pulses
always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_signal_o  <= '0;
        border_color_o <= `BORDER_RESET;
        vid_left_o     <= '0;
        vid_right_o    <= video_gen_pkg::hres_t'(`H_VISIBLE);
        colorbase_o    <= '0;
        blank_o        <= 1'b1;                             // playfield starts blanked
        disp_addr_o    <= '0;
        line_len_o     <= video_gen_pkg::word_t'(`H_VISIBLE / 2);
    end else begin
        intr_signal_o <= '0;                                // pulses last one clock

        if (reg_wr_en_i) begin
            case (reg_num_i)
                video_gen_pkg::reg_num_t'(`XR_VID_CTRL): begin
                    border_color_o <= reg_data_i[15:8];
                    intr_signal_o  <= reg_data_i[3:0];      // software interrupt
                end
                video_gen_pkg::reg_num_t'(`XR_VID_LEFT): begin
                    vid_left_o <= video_gen_pkg::hres_t'(reg_data_i);
                end
                video_gen_pkg::reg_num_t'(`XR_VID_RIGHT): begin
                    vid_right_o <= video_gen_pkg::hres_t'(reg_data_i);
                end
                video_gen_pkg::reg_num_t'(`XR_PA_GFX_CTRL): begin
                    colorbase_o <= reg_data_i[15:8];
                    blank_o     <= reg_data_i[7];
                end
                video_gen_pkg::reg_num_t'(`XR_PA_DISP_ADDR): begin
                    disp_addr_o <= reg_data_i;
                end
                video_gen_pkg::reg_num_t'(`XR_PA_LINE_LEN): begin
                    line_len_o <= reg_data_i;
                end
                default: begin
                end
            endcase
        end

        if (end_of_visible_i) begin
            intr_signal_o[`VSYNC_INTR] <= 1'b1;             // once per frame
        end
    end
end

// read-back selection
always_comb begin
    case (reg_num_i)
        video_gen_pkg::reg_num_t'(`XR_VID_CTRL):     rd_data = {border_color_o, 8'h00};
        video_gen_pkg::reg_num_t'(`XR_VID_LEFT):     rd_data = video_gen_pkg::word_t'(vid_left_o);
        video_gen_pkg::reg_num_t'(`XR_VID_RIGHT):    rd_data = video_gen_pkg::word_t'(vid_right_o);
        video_gen_pkg::reg_num_t'(`XR_SCANLINE):     rd_data = video_gen_pkg::word_t'(v_count_i);
        video_gen_pkg::reg_num_t'(`XR_VID_HSIZE):    rd_data = video_gen_pkg::word_t'(`H_VISIBLE);
        video_gen_pkg::reg_num_t'(`XR_VID_VSIZE):    rd_data = video_gen_pkg::word_t'(`V_VISIBLE);
        video_gen_pkg::reg_num_t'(`XR_PA_GFX_CTRL):  rd_data = {colorbase_o, blank_o, 7'b0};
        video_gen_pkg::reg_num_t'(`XR_PA_DISP_ADDR): rd_data = disp_addr_o;
        video_gen_pkg::reg_num_t'(`XR_PA_LINE_LEN):  rd_data = line_len_o;
        default:                                     rd_data = '0;
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o <= rd_data;
end

endmodule

`default_nettype wire

// File: verilog/video_playfield.sv
`default_nettype none
`timescale 1ns/1ns

`include "video_gen_params.svh"

module video_playfield (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire video_gen_pkg::hres_t   h_count_i,          // current column
    input  wire logic                   v_visible_i,
    input  wire logic                   end_of_line_i,
    input  wire video_gen_pkg::color_t  border_color_i,
    input  wire video_gen_pkg::color_t  colorbase_i,        // XORed into every pixel
    input  wire logic                   blank_i,
    input  wire video_gen_pkg::hres_t   vid_left_i,         // first unbordered visible column
    input  wire video_gen_pkg::hres_t   vid_right_i,        // first bordered column on the right
    input  wire video_gen_pkg::word_t   disp_addr_i,        // frame start address
    input  wire video_gen_pkg::word_t   line_len_i,         // words per line
    output      logic                   vram_sel_o,
    output      video_gen_pkg::addr_t   vram_addr_o,
    input  wire video_gen_pkg::word_t   vram_data_i,        // valid one clock after vram_sel_o
    output      video_gen_pkg::color_t  color_index_o       // pixel for the previous column
);

// fetch window covers H_VISIBLE clocks, with sel landing MEM_LEAD clocks ahead of pixel 0
localparam video_gen_pkg::hres_t FETCH_BEGIN = video_gen_pkg::hres_t'(`H_OFFSCREEN - `MEM_LEAD - 1);
localparam video_gen_pkg::hres_t FETCH_END   = video_gen_pkg::hres_t'(`H_TOTAL - `MEM_LEAD - 1);
localparam video_gen_pkg::hres_t VIS_START   = video_gen_pkg::hres_t'(`H_OFFSCREEN);

video_gen_pkg::addr_t   line_addr;                          // first word of the current line
logic                   fetch_go;                           // inside the fetch window
logic                   rd_valid;                           // vram_data_i holds a fetched word
video_gen_pkg::word_t   fetch_word;                         // word waiting for its pixel slot
video_gen_pkg::word_t   pix_word;                           // word being unpacked
video_gen_pkg::hres_t   vis_x;                              // visible column index
video_gen_pkg::color_t  pix_byte;
logic                   in_border;

assign fetch_go  = v_visible_i && !blank_i &&
                   (h_count_i >= FETCH_BEGIN) && (h_count_i < FETCH_END);
assign vis_x     = h_count_i - VIS_START;                   // wraps high in offscreen columns
assign pix_byte  = vis_x[0] ? pix_word[7:0] : pix_word[15:8];  // high byte first
assign in_border = blank_i || (vis_x < vid_left_i) || (vis_x >= vid_right_i);

always_ff @(posedge clk) begin
    if (reset_i) begin
        line_addr   <= '0;
        vram_sel_o  <= 1'b0;
        vram_addr_o <= '0;
        rd_valid    <= 1'b0;
    end else begin
        // one read on every other clock of the window
        vram_sel_o <= fetch_go && !vram_sel_o;
        rd_valid   <= vram_sel_o;

        if (!fetch_go) begin
            vram_addr_o <= line_addr;                       // rewind for the next line
        end else if (vram_sel_o) begin
            vram_addr_o <= vram_addr_o + video_gen_pkg::addr_t'(1);
        end

        // line stepping, reloaded from the start address during vertical blank
        if (end_of_line_i) begin
            if (v_visible_i) begin
                line_addr <= line_addr + line_len_i;
            end else begin
                line_addr <= disp_addr_i;
            end
        end
    end
end

// pixel pipeline
always_ff @(posedge clk) begin
    if (rd_valid) begin
        fetch_word <= vram_data_i;
    end
    if (vis_x[0]) begin
        pix_word <= fetch_word;                             // next column starts a new word
    end
    color_index_o <= in_border ? border_color_i : (pix_byte ^ colorbase_i);
end

endmodule

`default_nettype wire

// File: verilog/video_gen.sv
`default_nettype none
`timescale 1ns/1ns

module video_gen (
    input  wire logic                       clk,
    input  wire logic                       reset_i,
    input  wire logic                       reg_wr_en_i,
    input  wire video_gen_pkg::reg_num_t    reg_num_i,
    input  wire video_gen_pkg::word_t       reg_data_i,
    output      video_gen_pkg::word_t       reg_data_o,
    output      video_gen_pkg::intr_t       intr_signal_o,
    output      logic                       vram_sel_o,
    output      video_gen_pkg::addr_t       vram_addr_o,
    input  wire video_gen_pkg::word_t       vram_data_i,
    output      logic                       hsync_o,
    output      logic                       vsync_o,
    output      logic                       h_blank_o,
    output      logic                       v_blank_o,
    output      logic                       dv_de_o,
    output      video_gen_pkg::color_t      color_index_o
);

video_gen_pkg::hres_t   h_count;
video_gen_pkg::vres_t   v_count;
logic                   h_visible;
logic                   v_visible;
logic                   end_of_line;
logic                   end_of_visible;
logic                   hsync;
logic                   vsync;
logic                   dv_de;

video_gen_pkg::color_t  border_color;
video_gen_pkg::color_t  colorbase;
logic                   blank;
video_gen_pkg::hres_t   vid_left;
video_gen_pkg::hres_t   vid_right;
video_gen_pkg::word_t   disp_addr;
video_gen_pkg::word_t   line_len;
video_gen_pkg::color_t  pf_color;                           // pixel one clock behind the counters

video_timing video_timing_i (
    .clk(clk),
    .reset_i(reset_i),
    .h_count_o(h_count),
    .v_count_o(v_count),
    .h_visible_o(h_visible),
    .v_visible_o(v_visible),
    .end_of_line_o(end_of_line),
    .end_of_visible_o(end_of_visible),
    .hsync_o(hsync),
    .vsync_o(vsync),
    .dv_de_o(dv_de)
);

video_regs video_regs_i (
    .clk(clk),
    .reset_i(reset_i),
    .reg_wr_en_i(reg_wr_en_i),
    .reg_num_i(reg_num_i),
    .reg_data_i(reg_data_i),
    .v_count_i(v_count),
    .end_of_visible_i(end_of_visible),
    .reg_data_o(reg_data_o),
    .intr_signal_o(intr_signal_o),
    .border_color_o(border_color),
    .colorbase_o(colorbase),
    .blank_o(blank),
    .vid_left_o(vid_left),
    .vid_right_o(vid_right),
    .disp_addr_o(disp_addr),
    .line_len_o(line_len)
);

video_playfield video_playfield_i (
    .clk(clk),
    .reset_i(reset_i),
    .h_count_i(h_count),
    .v_visible_i(v_visible),
    .end_of_line_i(end_of_line),
    .border_color_i(border_color),
    .colorbase_i(colorbase),
    .blank_i(blank),
    .vid_left_i(vid_left),
    .vid_right_i(vid_right),
    .disp_addr_i(disp_addr),
    .line_len_i(line_len),
    .vram_sel_o(vram_sel_o),
    .vram_addr_o(vram_addr_o),
    .vram_data_i(vram_data_i),
    .color_index_o(pf_color)
);

// output stage, timing levels and pixel leave together
always_ff @(posedge clk) begin
    if (reset_i) begin
        hsync_o   <= 1'b0;
        vsync_o   <= 1'b0;
        h_blank_o <= 1'b1;
        v_blank_o <= 1'b1;
        dv_de_o   <= 1'b0;
    end else begin
        hsync_o   <= hsync;
        vsync_o   <= vsync;
        h_blank_o <= ~h_visible;
        v_blank_o <= ~v_visible;
        dv_de_o   <= dv_de;
    end
end

always_ff @(posedge clk) begin
    color_index_o <= pf_color;
end

endmodule

`default_nettype wire

// File: tb/video_gen_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "video_gen_params.svh"

module video_gen_tb;

logic                       clk;
logic                       reset_i;
logic                       reg_wr_en_i;
video_gen_pkg::reg_num_t    reg_num_i;
video_gen_pkg::word_t       reg_data_i;
video_gen_pkg::word_t       reg_data_o;
video_gen_pkg::intr_t       intr_signal_o;
logic                       vram_sel_o;
video_gen_pkg::addr_t       vram_addr_o;
video_gen_pkg::word_t       vram_data;
logic                       hsync_o;
logic                       vsync_o;
logic                       h_blank_o;
logic                       v_blank_o;
logic                       dv_de_o;
video_gen_pkg::color_t      color_index_o;

video_gen_pkg::word_t       vram [0:65535];
logic [7:0]                 ops [$];                        // command letters from the input file
logic [5:0]                 nums [$];
logic [15:0]                datas [$];
logic [15:0]                exps [$];
int unsigned                cycle_count = 0;
int unsigned                limit = '1;                     // set once the commands are read

// register state as software sees it after its writes
logic [7:0]                 border_reg = `BORDER_RESET;
logic [7:0]                 colorbase_reg = 8'h00;
logic                       blank_reg = 1'b1;
int                         left_reg = 0;
int                         right_reg = `H_VISIBLE;
logic [31:0]                disp_reg = 0;
logic [31:0]                len_reg = `H_VISIBLE / 2;

video_gen video_gen_i (
    .clk(clk),
    .reset_i(reset_i),
    .reg_wr_en_i(reg_wr_en_i),
    .reg_num_i(reg_num_i),
    .reg_data_i(reg_data_i),
    .reg_data_o(reg_data_o),
    .intr_signal_o(intr_signal_o),
    .vram_sel_o(vram_sel_o),
    .vram_addr_o(vram_addr_o),
    .vram_data_i(vram_data),
    .hsync_o(hsync_o),
    .vsync_o(vsync_o),
    .h_blank_o(h_blank_o),
    .v_blank_o(v_blank_o),
    .dv_de_o(dv_de_o),
    .color_index_o(color_index_o)
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

always @(negedge clk) begin
    if (vram_sel_o) begin
        vram_data <= vram[vram_addr_o];                     // seen by the DUT on the next clock
    end
end

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= limit) begin
        $display("timeout: the run went past %0d cycles without finishing", limit);
        $display("Errors found");
        $fatal(1);
    end
end

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end else begin
        return state >> 1;
    end
endfunction

task automatic compare_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
        $display("mismatch %s: got %h, expected %h", name, actual, expected);
        $display("Errors found");
        $fatal(1);
    end
endtask

task automatic write_reg(input logic [5:0] num, input logic [15:0] data,
                         input logic [15:0] intr_exp);
    @(negedge clk);
    reg_wr_en_i = 1'b1;
    reg_num_i   = num;
    reg_data_i  = data;
    @(negedge clk);
    reg_wr_en_i = 1'b0;
    compare_value("intr_signal_o", 32'(intr_signal_o), 32'(intr_exp));
    case (num)
        `XR_VID_CTRL:     border_reg = data[15:8];
        `XR_VID_LEFT:     left_reg = 32'(data[5:0]);
        `XR_VID_RIGHT:    right_reg = 32'(data[5:0]);
        `XR_PA_GFX_CTRL: begin
            colorbase_reg = data[15:8];
            blank_reg     = data[7];
        end
        `XR_PA_DISP_ADDR: disp_reg = 32'(data);
        `XR_PA_LINE_LEN:  len_reg = 32'(data);
        default: begin
        end
    endcase
    @(negedge clk);
    compare_value("intr_signal_o", 32'(intr_signal_o), 32'h0);  // pulse lasts one clock
endtask

task automatic read_reg(input logic [5:0] num, input logic [15:0] expected);
    @(negedge clk);
    reg_num_i = num;
    @(negedge clk);
    compare_value("reg_data_o", 32'(reg_data_o), 32'(expected));
endtask

// checks one frame period that starts just after an end of visible pulse
task automatic check_frame();
    int          run;
    int          lines;
    int          n_hs;
    int          n_vs;
    int          n_hb;
    int          n_vb;
    int          n_intr;
    int          n_sel;
    int          pos;
    logic [31:0] addr;
    logic [15:0] pix_word;
    logic [7:0]  pix;
    run    = 0;
    lines  = 0;
    n_hs   = 0;
    n_vs   = 0;
    n_hb   = 0;
    n_vb   = 0;
    n_intr = 0;
    n_sel  = 0;
    @(negedge clk);
    while (!intr_signal_o[`VSYNC_INTR]) @(negedge clk);
    @(negedge clk);                                         // last pixel of the old frame
    reg_num_i = `XR_SCANLINE;
    pos       = `V_VISIBLE * `H_TOTAL + 1;                  // frame position the read-back shows
    repeat (`H_TOTAL * `V_TOTAL) begin
        @(negedge clk);
        compare_value("reg_data_o scanline", 32'(reg_data_o),
                      32'((pos / `H_TOTAL) % `V_TOTAL));
        pos++;
        if (dv_de_o) begin
            compare_value("h_blank_o", 32'(h_blank_o), 32'h0);
            compare_value("v_blank_o", 32'(v_blank_o), 32'h0);
            addr     = disp_reg + 32'(lines) * len_reg + 32'(run / 2);
            pix_word = vram[addr[15:0]];
            pix      = (run % 2 == 1) ? pix_word[7:0] : pix_word[15:8];
            if (blank_reg || run < left_reg || run >= right_reg) begin
                pix = border_reg;
            end else begin
                pix = pix ^ colorbase_reg;
            end
            compare_value("color_index_o", 32'(color_index_o), 32'(pix));
            run++;
        end else if (run != 0) begin
            compare_value("dv_de_o width", run, `H_VISIBLE);
            lines++;
            run = 0;
        end
        if (hsync_o) n_hs++;
        if (vsync_o) n_vs++;
        if (!h_blank_o) n_hb++;
        if (!v_blank_o) n_vb++;
        if (intr_signal_o[`VSYNC_INTR]) n_intr++;
        if (vram_sel_o) n_sel++;
    end
    if (run != 0) begin
        compare_value("dv_de_o width", run, `H_VISIBLE);
        lines++;
    end
    compare_value("dv_de_o lines", lines, `V_VISIBLE);
    compare_value("hsync_o cycles", n_hs, (`H_SYNC_END - `H_SYNC_START) * `V_TOTAL);
    compare_value("vsync_o cycles", n_vs, (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL);
    compare_value("h_blank_o low cycles", n_hb, `H_VISIBLE * `V_TOTAL);
    compare_value("v_blank_o low cycles", n_vb, `V_VISIBLE * `H_TOTAL);
    compare_value("intr_signal_o frame pulses", n_intr, 1);
    if (blank_reg) begin
        compare_value("vram_sel_o while blanked", n_sel, 0);
    end else begin
        compare_value("vram_sel_o reads", n_sel, `V_VISIBLE * `H_VISIBLE / 2);  // two pixels a word
    end
endtask

initial begin : run_tests
    int           fd;
    int           cnt;
    logic [31:0]  state;
    logic [15:0]  w;
    logic [8*96-1:0] line;
    logic [7:0]   op;
    logic [31:0]  num_f;
    logic [31:0]  data_f;
    logic [31:0]  exp_f;
    reset_i     = 1'b1;
    reg_wr_en_i = 1'b0;
    reg_num_i   = '0;
    reg_data_i  = '0;
    vram_data   = '0;
    state       = 32'hfe92cf0a;
    for (int a = 0; a < 65536; a++) begin
        w = '0;
        for (int b = 0; b < 16; b++) begin
            w     = {w[14:0], state[0]};                    // one step per bit
            state = lfsr_next(state);
        end
        vram[a] = w;
    end
    fd = $fopen("tb/video_gen_input.txt", "r");
    if (fd == 0) begin
        $display("could not open the command file tb/video_gen_input.txt");
        $display("Errors found");
        $fatal(1);
    end
    while ($fgets(line, fd) != 0) begin
        cnt = $sscanf(line, "%s %h %h %h", op, num_f, data_f, exp_f);
        if (cnt == 4) begin                                 // comment lines fall through
            ops.push_back(op);
            nums.push_back(num_f[5:0]);
            datas.push_back(data_f[15:0]);
            exps.push_back(exp_f[15:0]);
        end
    end
    $fclose(fd);
    limit = ops.size() * (`H_TOTAL * `V_TOTAL + 10);
    repeat (16) @(negedge clk);
    reset_i = 1'b0;
    for (int i = 0; i < ops.size(); i++) begin
        case (ops[i])
            "W": write_reg(nums[i], datas[i], exps[i]);
            "R": read_reg(nums[i], exps[i]);
            "F": check_frame();
            default: begin
                $display("unknown command letter in line %0d of the command file", i);
                $display("Errors found");
                $fatal(1);
            end
        endcase
    end
    $display("No errors");
    $finish;
end

endmodule

`default_nettype wire

// File: tb/video_gen_input.txt
# op reg data expect, all hex; W expect is intr_signal_o after the write, R expect is read data
# F checks the next full frame, its other fields are ignored
R 00 0000 0800
R 04 0000 0000
R 05 0000 0020
R 0a 0000 0020
R 0b 0000 0008
R 10 0000 0080
R 13 0000 0010
R 07 0000 0000
F 00 0000 0000
W 00 3106 0006
W 12 1234 0000
W 13 0015 0000
W 10 a500 0000
R 00 0000 3100
R 10 0000 a500
R 12 0000 1234
F 00 0000 0000
W 04 0003 0000
W 05 001d 0000
R 05 0000 001d
F 00 0000 0000

// File: tb.f
+incdir+verilog
verilog/video_gen_pkg.sv
verilog/video_timing.sv
verilog/video_regs.sv
verilog/video_playfield.sv
verilog/video_gen.sv
tb/video_gen_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ns --top-module video_gen_tb -f tb.f -o video_gen_sim &&
obj_dir/video_gen_sim || { echo "simulation failed"; exit 1; }
